// File: flist.f
design/opn_pkg.sv
design/opn_cen_gen.sv
design/opn_regs.sv
design/opn_timer.sv
design/opn_status.sv
design/opn_top.sv
verif/opn_clk_gen.sv
verif/opn_props.sv
verif/opn_tb.sv

// File: verif/opn_tb.sv
// **************************************************
// Testbench for the FM chip control core
// Random bus traffic from a fixed seed, cycle model
// Inputs change on the rising edge, outputs are compared
// on the falling edge of every cycle after reset
// Model assumes the default PRESCALE and BUSY_CYCLES
// **************************************************

`timescale 1ns/1ps

module opn_tb import opn_pkg::*; ();

    localparam int PRESCALE       = 6;
    localparam int BUSY_CYCLES    = 32;
    localparam int N_OPS          = 250;
    localparam int MAX_GAP        = 60;
    localparam int DRAIN          = 2000;   // Longer than one timer B period
    localparam int PLAN_CYCLES    = 40 + N_OPS * (MAX_GAP + 4) + DRAIN;
    localparam int TIMEOUT_CYCLES = 20 * PLAN_CYCLES;

    logic       clk;
    logic       rst_n;
    logic       cen;
    logic [7:0] din;
    logic [1:0] addr;
    logic       cs_n;
    logic       wr_n;
    status_t    dout;
    logic       irq_n;

    // Model state
    int           pre_cnt;
    logic         m_tick;
    logic [7:0]   m_addr_lat;
    timer_cfg_t   m_cfg;
    timer_a_cnt_t m_cnt_a;
    timer_b_cnt_t m_cnt_b;
    logic [3:0]   m_sub_b;
    logic         m_flag_a;
    logic         m_flag_b;
    int           busy_left;
    status_t      m_dout;
    int           sets_a;
    int           sets_b;

    int status_errors;
    int irq_errors;
    int other_errors;
    int cycles;

    opn_clk_gen #(.PERIOD_NS(8), .RESET_CYCLES(4)) u_clk_gen (.clk(clk), .rst_n(rst_n));

    opn_top opn_top_inst (
        .clk   (clk),
        .rst_n (rst_n),
        .cen   (cen),
        .din   (din),
        .addr  (addr),
        .cs_n  (cs_n),
        .wr_n  (wr_n),
        .dout  (dout),
        .irq_n (irq_n)
    );

    task automatic check_status(input status_t expected, input status_t actual);
        if (actual !== expected) begin
            status_errors++;
            $display("FAILED at %0t: dout expected %h, got %h", $time, expected, actual);
        end
    endtask

    task automatic check_irq(input logic expected, input logic actual);
        if (actual !== expected) begin
            irq_errors++;
            $display("FAILED at %0t: irq_n expected %b, got %b", $time, expected, actual);
        end
    endtask

    // Cycle model updated with the inputs sampled at this edge
    always @(posedge clk) begin : model
        logic bus_wr;
        logic step_a;
        logic step_b;
        logic ovf_a;
        logic ovf_b;
        if (!rst_n) begin
            pre_cnt    = 0;
            m_tick     = 1'b0;
            m_addr_lat = '0;
            m_cfg      = '0;
            m_cnt_a    = '0;
            m_cnt_b    = '0;
            m_sub_b    = '0;
            m_flag_a   = 1'b0;
            m_flag_b   = 1'b0;
            busy_left  = 0;
            m_dout     = '0;
        end else begin
            m_dout.busy   = (busy_left != 0);  // Previous cycle state
            m_dout.rsvd   = '0;
            m_dout.flag_b = m_flag_b;
            m_dout.flag_a = m_flag_a;
            step_a = m_tick && m_cfg.ctl_a.load;
            ovf_a  = step_a && (m_cnt_a == 10'h3ff);
            if (ovf_a && m_cfg.ctl_a.irq_en) begin
                m_flag_a = 1'b1;
                sets_a++;
            end else if (m_cfg.ctl_a.clr_flag) begin
                m_flag_a = 1'b0;
            end
            if (!m_cfg.ctl_a.load || ovf_a) m_cnt_a = m_cfg.value_a;
            else if (step_a) m_cnt_a = m_cnt_a + 1'b1;
            // Timer B main count steps once per 16 ticks
            step_b = m_tick && m_cfg.ctl_b.load && (m_sub_b == 4'hf);
            ovf_b  = step_b && (m_cnt_b == 8'hff);
            if (ovf_b && m_cfg.ctl_b.irq_en) begin
                m_flag_b = 1'b1;
                sets_b++;
            end else if (m_cfg.ctl_b.clr_flag) begin
                m_flag_b = 1'b0;
            end
            if (!m_cfg.ctl_b.load || ovf_b) m_cnt_b = m_cfg.value_b;
            else if (step_b) m_cnt_b = m_cnt_b + 1'b1;
            if (!m_cfg.ctl_b.load) m_sub_b = '0;
            else if (m_tick) m_sub_b = m_sub_b + 1'b1;
            bus_wr = !cs_n && !wr_n;
            if (bus_wr && addr == 2'd1) busy_left = BUSY_CYCLES;
            else if (busy_left > 0) busy_left--;
            m_tick = 1'b0;
            if (cen) begin
                if (pre_cnt == PRESCALE - 1) begin
                    pre_cnt = 0;
                    m_tick  = 1'b1;
                end else begin
                    pre_cnt++;
                end
            end
            m_cfg.ctl_a.clr_flag = 1'b0;
            m_cfg.ctl_b.clr_flag = 1'b0;
            if (bus_wr && addr == 2'd0) begin
                m_addr_lat = din;
            end else if (bus_wr && addr == 2'd1) begin
                case (m_addr_lat)
                    ADDR_TIMER_A_HI: m_cfg.value_a[9:2] = din;
                    ADDR_TIMER_A_LO: m_cfg.value_a[1:0] = din[1:0];
                    ADDR_TIMER_B:    m_cfg.value_b = din;
                    ADDR_TIMER_CTL: begin
                        m_cfg.ctl_a = '{din[CTL_LOAD_A], din[CTL_EN_A], din[CTL_CLR_A]};
                        m_cfg.ctl_b = '{din[CTL_LOAD_B], din[CTL_EN_B], din[CTL_CLR_B]};
                    end
                    default: ;
                endcase
            end
        end
    end

    always @(negedge clk) begin
        if (rst_n) begin
            check_status(m_dout, dout);
            check_irq(~(m_flag_a | m_flag_b), irq_n);
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, the test did not finish", cycles);
            $display("Something failed");
            $finish;
        end
    end

    task automatic bus_cycle(input logic wr, input logic [1:0] a, input logic [7:0] d);
        @(posedge clk);
        cen  <= ($urandom_range(0, 3) != 0);  // High three cycles in four
        cs_n <= ~wr;
        wr_n <= ~wr;
        addr <= a;
        din  <= d;
    endtask

    task automatic idle_cycles(input int n);
        logic sel;
        repeat (n) begin
            @(posedge clk);
            sel = $urandom_range(0, 1);
            cen  <= ($urandom_range(0, 3) != 0);
            cs_n <= ~sel;
            // Selected without strobe, or strobe without select
            wr_n <= sel ? 1'b1 : 1'($urandom_range(0, 1));
            addr <= $urandom_range(0, 3);
            din  <= $urandom_range(0, 255);
        end
    endtask

    task automatic reg_write(input logic [7:0] reg_addr, input logic [7:0] data);
        bus_cycle(1'b1, 2'd0, reg_addr);
        bus_cycle(1'b1, 2'd1, data);
    endtask

    function automatic logic [7:0] random_ctl();
        logic [7:0] b;
        b = $urandom_range(0, 255);
        b[CTL_LOAD_A] = ($urandom_range(0, 7) != 0);
        b[CTL_LOAD_B] = ($urandom_range(0, 7) != 0);
        b[CTL_EN_A]   = ($urandom_range(0, 3) != 0);
        b[CTL_EN_B]   = ($urandom_range(0, 3) != 0);
        b[CTL_CLR_A]  = ($urandom_range(0, 3) == 0);
        b[CTL_CLR_B]  = ($urandom_range(0, 3) == 0);
        return b;
    endfunction

    initial begin : stimulus
        int           op;
        timer_a_cnt_t val_a;
        logic [7:0]   other;
        void'($urandom(32'h7c61516c));
        cen  = 1'b0;
        din  = '0;
        addr = '0;
        cs_n = 1'b1;
        wr_n = 1'b1;
        do idle_cycles(1); while (rst_n !== 1'b1);
        idle_cycles(20);
        val_a = $urandom_range(1000, 1023);
        reg_write(ADDR_TIMER_A_HI, val_a[9:2]);
        reg_write(ADDR_TIMER_A_LO, {6'($urandom_range(0, 63)), val_a[1:0]});
        reg_write(ADDR_TIMER_B, $urandom_range(250, 255));
        reg_write(ADDR_TIMER_CTL, 8'h0f);
        for (int i = 0; i < N_OPS; i++) begin
            op = $urandom_range(0, 9);
            case (op)
                0, 1: begin
                    val_a = $urandom_range(1000, 1023);
                    reg_write(ADDR_TIMER_A_HI, val_a[9:2]);
                    reg_write(ADDR_TIMER_A_LO, {6'($urandom_range(0, 63)), val_a[1:0]});
                end
                2: reg_write(ADDR_TIMER_B, $urandom_range(250, 255));
                3, 4: reg_write(ADDR_TIMER_CTL, random_ctl());
                5: begin
                    do other = $urandom_range(0, 255); while (other inside {[8'h24:8'h27]});
                    reg_write(other, $urandom_range(0, 255));
                end
                6: bus_cycle(1'b1, 2'($urandom_range(2, 3)), $urandom_range(0, 255)); // Port 1
                default: ;
            endcase
            idle_cycles($urandom_range(0, MAX_GAP));
        end
        // Random traffic alone has to reach both overflows
        if (sets_a == 0) begin
            other_errors++;
            $display("Timer A never overflowed with its interrupt enabled");
        end
        if (sets_b == 0) begin
            other_errors++;
            $display("Timer B never overflowed with its interrupt enabled");
        end
        // Both timers running with interrupts on before the end
        reg_write(ADDR_TIMER_CTL, 8'h0f);
        idle_cycles(DRAIN);
        @(negedge clk);
        $display("Errors: dout %0d, irq_n %0d, other %0d", status_errors, irq_errors,
                 other_errors);
        if (status_errors + irq_errors + other_errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// File: verif/opn_props.sv
// **************************************************
// Concurrent checks on the control core internals
// Bound to opn_top, sampled on the rising clk edge
// All checks are disabled while rst_n is low
// **************************************************

`timescale 1ns/1ps

module opn_props import opn_pkg::*; (
    input logic    clk,
    input logic    rst_n,
    input logic    clk_en,
    input logic    data_wr,
    input logic    flag_a,
    input logic    flag_b,
    input logic    irq_n,
    input status_t dout
);

    // Interrupt is the inverted OR of both flags
    irq_matches_flags: assert property (@(posedge clk) disable iff (!rst_n)
        irq_n == !(flag_a || flag_b))
        else $error("irq_n does not follow the timer flags");

    // Tick is a single-cycle pulse
    tick_single_cycle: assert property (@(posedge clk) disable iff (!rst_n)
        clk_en |=> !clk_en)
        else $error("clk_en was high in two consecutive cycles");

    // Busy reaches dout one cycle after the internal busy rises
    busy_after_write: assert property (@(posedge clk) disable iff (!rst_n)
        data_wr |=> ##1 dout.busy)
        else $error("dout busy bit missing after a data write");

endmodule

bind opn_top opn_props u_props (
    .clk     (clk),
    .rst_n   (rst_n),
    .clk_en  (clk_en),
    .data_wr (data_wr),
    .flag_a  (flag_a),
    .flag_b  (flag_b),
    .irq_n   (irq_n),
    .dout    (dout)
);

// File: verif/opn_clk_gen.sv
// **************************************************
// Testbench clock and reset source
// rst_n is low for RESET_CYCLES rising edges
// It is released with a non-blocking update on an edge
// **************************************************

`timescale 1ns/1ps

module opn_clk_gen #(
    parameter int PERIOD_NS    = 8,
    parameter int RESET_CYCLES = 4
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;  // Synchronous release
    end

endmodule

// File: design/opn_top.sv
// **************************************************
// FM chip control core, top level
// Write bus, timer prescaler, timers A and B, status
// No sound generation, register port 1 is ignored
// Reads always return the status byte
// **************************************************

`timescale 1ns/1ps

module opn_top import opn_pkg::*; #(
    parameter int PRESCALE    = 6,
    parameter int BUSY_CYCLES = 32
) (
    input  logic       clk,    // CPU clock
    input  logic       rst_n,
    input  logic       cen,    // External clock enable
    input  logic [7:0] din,
    input  logic [1:0] addr,
    input  logic       cs_n,
    input  logic       wr_n,
    output status_t    dout,
    output logic       irq_n
);

    logic       clk_en;
    logic       data_wr;
    logic       flag_a;
    logic       flag_b;
    timer_cfg_t cfg;

    opn_cen_gen #(
        .PRESCALE (PRESCALE)
    ) u_cen_gen (
        .clk    (clk),
        .rst_n  (rst_n),
        .cen    (cen),
        .clk_en (clk_en)
    );

    opn_regs u_regs (
        .clk     (clk),
        .rst_n   (rst_n),
        .din     (din),
        .addr    (addr),
        .cs_n    (cs_n),
        .wr_n    (wr_n),
        .cfg     (cfg),
        .data_wr (data_wr)
    );

    // Timer A runs on the direct tick
    opn_timer #(
        .cnt_t    (timer_a_cnt_t),
        .SUB_BITS (0)
    ) u_timer_a (
        .clk   (clk),
        .rst_n (rst_n),
        .tick  (clk_en),
        .value (cfg.value_a),
        .ctl   (cfg.ctl_a),
        .flag  (flag_a)
    );

    // Timer B runs 16 times slower
    opn_timer #(
        .cnt_t    (timer_b_cnt_t),
        .SUB_BITS (4)
    ) u_timer_b (
        .clk   (clk),
        .rst_n (rst_n),
        .tick  (clk_en),
        .value (cfg.value_b),
        .ctl   (cfg.ctl_b),
        .flag  (flag_b)
    );

    opn_status #(
        .BUSY_CYCLES (BUSY_CYCLES)
    ) u_status (
        .clk     (clk),
        .rst_n   (rst_n),
        .data_wr (data_wr),
        .flag_a  (flag_a),
        .flag_b  (flag_b),
        .dout    (dout),
        .irq_n   (irq_n)
    );

endmodule

// File: design/opn_status.sv
// **************************************************
// Busy timing, status byte and interrupt
// busy lasts BUSY_CYCLES clk cycles after a data write
// dout lags the internal state by one cycle
// irq_n is combinational from the two flags
// **************************************************

`timescale 1ns/1ps

module opn_status import opn_pkg::*; #(
    parameter int BUSY_CYCLES = 32
) (
    input  logic    clk,
    input  logic    rst_n,
    input  logic    data_wr,
    input  logic    flag_a,
    input  logic    flag_b,
    output status_t dout,
    output logic    irq_n
);

    localparam int BW = $clog2(BUSY_CYCLES + 1);

    logic [BW-1:0] busy_cnt;
    logic          busy;

    // A write while busy restarts the interval
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy_cnt <= '0;
        end else if (data_wr) begin
            busy_cnt <= BW'(BUSY_CYCLES);
        end else if (busy) begin
            busy_cnt <= busy_cnt - 1'b1;
        end
    end

    assign busy = (busy_cnt != '0);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            dout <= '0;
        end else begin
            dout.busy   <= busy;
            dout.rsvd   <= '0;
            dout.flag_b <= flag_b;
            dout.flag_a <= flag_a;
        end
    end

    assign irq_n = ~(flag_a | flag_b);  // Low while any flag is set

endmodule

// File: design/opn_timer.sv
// **************************************************
// Reload timer with overflow flag
// Count follows value while load is low
// SUB_BITS > 0 adds a 2^SUB_BITS tick sub-prescaler
// Period is 2^SUB_BITS * (2^width - value) ticks
// Flag set wins over a clear in the same cycle
// **************************************************

`timescale 1ns/1ps

module opn_timer import opn_pkg::*; #(
    parameter type cnt_t    = timer_a_cnt_t,
    parameter int  SUB_BITS = 0
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       tick,    // Internal clock enable
    input  cnt_t       value,   // Reload value
    input  timer_ctl_t ctl,
    output logic       flag
);

    cnt_t cnt;
    logic step;       // Main count advances
    logic overflow;

    generate
        if (SUB_BITS > 0) begin : g_sub
            logic [SUB_BITS-1:0] sub_cnt;

            always_ff @(posedge clk) begin
                if (!rst_n || !ctl.load) begin
                    sub_cnt <= '0;
                end else if (tick) begin
                    sub_cnt <= sub_cnt + 1'b1;
                end
            end

            // Main count moves when the sub-count wraps
            assign step = tick && ctl.load && (sub_cnt == '1);
        end else begin : g_nosub
            assign step = tick && ctl.load;
        end
    endgenerate

    assign overflow = step && (cnt == '1);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cnt <= '0;
        end else if (!ctl.load) begin
            cnt <= value;
        end else if (step) begin
            cnt <= overflow ? value : cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            flag <= 1'b0;
        end else if (overflow && ctl.irq_en) begin
            flag <= 1'b1;
        end else if (ctl.clr_flag) begin
            flag <= 1'b0;
        end
    end

endmodule

// File: design/opn_regs.sv
// **************************************************
// CPU write port and timer registers
// addr 0 latches the register address, addr 1 writes data
// addr 2 and 3 (port 1) are ignored
// Only 0x24..0x27 are stored, other addresses are dropped
// Flag reset bits of 0x27 come out as one-cycle pulses
// **************************************************

`timescale 1ns/1ps

module opn_regs import opn_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic [7:0] din,
    input  logic [1:0] addr,
    input  logic       cs_n,
    input  logic       wr_n,
    output timer_cfg_t cfg,
    output logic       data_wr   // Data write strobe in the bus cycle
);

    logic       write;
    logic       addr_wr;
    logic [7:0] addr_lat;   // Latched register address
    timer_cfg_t cfg_q;

    // Plain strobes without handshake
    assign write   = ~cs_n & ~wr_n;
    assign addr_wr = write && (addr == 2'd0);
    assign data_wr = write && (addr == 2'd1);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            addr_lat <= '0;
        end else if (addr_wr) begin
            addr_lat <= din;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cfg_q <= '0;
        end else begin
            // Clear pulses last one cycle only
            cfg_q.ctl_a.clr_flag <= 1'b0;
            cfg_q.ctl_b.clr_flag <= 1'b0;
            if (data_wr) begin
                case (addr_lat)
                    ADDR_TIMER_A_HI: begin
                        cfg_q.value_a[9:2] <= din;
                    end
                    ADDR_TIMER_A_LO: begin
                        cfg_q.value_a[1:0] <= din[1:0];  // Upper bits unused
                    end
                    ADDR_TIMER_B: begin
                        cfg_q.value_b <= din;
                    end
                    ADDR_TIMER_CTL: begin
                        cfg_q.ctl_a.load     <= din[CTL_LOAD_A];
                        cfg_q.ctl_b.load     <= din[CTL_LOAD_B];
                        cfg_q.ctl_a.irq_en   <= din[CTL_EN_A];
                        cfg_q.ctl_b.irq_en   <= din[CTL_EN_B];
                        cfg_q.ctl_a.clr_flag <= din[CTL_CLR_A];
                        cfg_q.ctl_b.clr_flag <= din[CTL_CLR_B];
                    end
                    default: begin
                        // Nothing stored for other registers
                    end
                endcase
            end
        end
    end

    assign cfg = cfg_q;

endmodule

// File: design/opn_cen_gen.sv
// **************************************************
// Internal tick prescaler
// clk_en is one clk cycle wide, PRESCALE cen pulses apart
// PRESCALE must be 2 or more for a one-cycle tick
// **************************************************

`timescale 1ns/1ps

module opn_cen_gen #(
    parameter int PRESCALE = 6
) (
    input  logic clk,
    input  logic rst_n,
    input  logic cen,     // External clock enable
    output logic clk_en   // Internal timer tick
);

    localparam int CW = (PRESCALE > 1) ? $clog2(PRESCALE) : 1;

    logic [CW-1:0] cnt;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cnt    <= '0;
            clk_en <= 1'b0;
        end else begin
            clk_en <= 1'b0;
            if (cen) begin
                if (cnt == CW'(PRESCALE - 1)) begin
                    cnt    <= '0;
                    clk_en <= 1'b1; // PRESCALE-th pulse seen
                end else begin
                    cnt <= cnt + 1'b1;
                end
            end
        end
    end

endmodule

// File: design/opn_pkg.sv
// **************************************************
// Shared definitions for the FM chip control core
// Only register port 0 and the timer registers exist
// Timer A is 10 bits wide and timer B is 8 bits wide
// **************************************************

package opn_pkg;

    // Register addresses, as latched through addr 0
    localparam logic [7:0] ADDR_TIMER_A_HI = 8'h24; // Timer A value bits 9..2
    localparam logic [7:0] ADDR_TIMER_A_LO = 8'h25; // Timer A value bits 1..0
    localparam logic [7:0] ADDR_TIMER_B    = 8'h26;
    localparam logic [7:0] ADDR_TIMER_CTL  = 8'h27;

    // Bit positions inside register 0x27
    localparam int CTL_LOAD_A = 0;
    localparam int CTL_LOAD_B = 1;
    localparam int CTL_EN_A   = 2;
    localparam int CTL_EN_B   = 3;
    localparam int CTL_CLR_A  = 4; // Flag reset pulse
    localparam int CTL_CLR_B  = 5;

    typedef logic [9:0] timer_a_cnt_t;
    typedef logic [7:0] timer_b_cnt_t;

    // Control of one timer
    typedef struct packed {
        logic load;      // Timer runs while set
        logic irq_en;    // Overflow may set the flag
        logic clr_flag;  // One-cycle pulse
    } timer_ctl_t;

    // Timer configuration as held by the register block
    typedef struct packed {
        timer_a_cnt_t value_a;
        timer_b_cnt_t value_b;
        timer_ctl_t   ctl_a;
        timer_ctl_t   ctl_b;
    } timer_cfg_t;

    // Status byte returned on reads
    typedef struct packed {
        logic       busy;    // Bit 7
        logic [4:0] rsvd;    // Always zero
        logic       flag_b;  // Bit 1
        logic       flag_a;  // Bit 0
    } status_t;

endpackage
